// File: common/msu_defines.svh
`ifndef MSU_DEFINES_SVH
`define MSU_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Buffer geometry
//////////////////////////////////////////////////////////////////////

// Data buffer and read pointer address width
`define MSU_BUF_AW 14
`define MSU_BUF_DEPTH (1 << `MSU_BUF_AW)

//////////////////////////////////////////////////////////////////////
// Console register widths
//////////////////////////////////////////////////////////////////////

`define MSU_DATA_W 8
`define MSU_REG_AW 3
`define MSU_SEEK_W 32
`define MSU_TRACK_W 16

`endif

// File: common/msu_regs_pkg.sv
`include "msu_defines.svh"
`default_nettype none

package msu_regs_pkg;

  //////////////////////////////////////////////////////////////////////
  // Console read map
  //////////////////////////////////////////////////////////////////////

  // Values follow declaration order, status at address 0
  typedef enum logic [`MSU_REG_AW-1:0] {
    RD_STATUS,
    RD_DATA,
    RD_ID0,
    RD_ID1,
    RD_ID2,
    RD_ID3,
    RD_ID4,
    RD_ID5
  } msu_rd_reg_e;

  //////////////////////////////////////////////////////////////////////
  // Console write map
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [`MSU_REG_AW-1:0] {
    WR_ADDR0,
    WR_ADDR1,
    WR_ADDR2,
    WR_ADDR3,
    WR_TRACK_LO,
    WR_TRACK_HI,
    WR_VOLUME,
    WR_CONTROL
  } msu_wr_reg_e;

  // "S-MSU1", index 0 is read at RD_ID0
  localparam logic [0:5][`MSU_DATA_W-1:0] MSU_ID = {
    8'h53, 8'h2d, 8'h4d, 8'h53, 8'h55, 8'h31
  };

  // Fixed revision code in the low nibble of the status byte
  localparam logic [3:0] MSU_STATUS_REV = 4'b0001;

endpackage

`default_nettype wire

// File: common/msu_mcu_pkg.sv
`default_nettype none

package msu_mcu_pkg;

  // Set and reset words strobed in by the microcontroller
  typedef struct packed {
    logic       audio_busy;
    logic       data_busy;
    logic       volume;        // not used by the register file
    logic [1:0] audio_status;
    logic       ctrl_start;
  } msu_status_bits_t;

  // Flags reported back to the microcontroller
  typedef struct packed {
    logic       ptr_msb;       // upper half of the buffer in use
    logic       audio_start;
    logic       data_start;
    logic       volume_latch;
    logic [1:0] audio_ctrl;
    logic       ctrl_start;
  } msu_status_out_t;

endpackage

`default_nettype wire

// File: common/msu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Synchronized console bus events, from the sampler to the register file
interface msu_bus_if;

  // Address as seen by the read mux, four clocks behind the pins
  msu_regs_pkg::msu_rd_reg_e rd_addr;
  // Address as seen by write decode, two clocks behind the pins
  msu_regs_pkg::msu_wr_reg_e wr_addr;

  // Single-cycle event pulses
  logic oe_rise;
  logic oe_fall;
  logic we_rise;
  logic ptr_load;
  logic status_update;

  modport sync (
    output rd_addr,
    output wr_addr,
    output oe_rise,
    output oe_fall,
    output we_rise,
    output ptr_load,
    output status_update
  );

  modport regs (
    input rd_addr,
    input wr_addr,
    input oe_rise,
    input oe_fall,
    input we_rise,
    input ptr_load,
    input status_update
  );

endinterface

`default_nettype wire

// File: msu/msu_databuf.sv
`timescale 1ns/1ps
`include "msu_defines.svh"
`default_nettype none

module msu_databuf (
  input  logic                   clkin,
  input  logic [`MSU_BUF_AW-1:0] wr_addr,
  input  logic [`MSU_DATA_W-1:0] wr_data,
  input  logic                   wr_en,
  input  logic [`MSU_BUF_AW-1:0] rd_addr,
  output logic [`MSU_DATA_W-1:0] rd_data
);

  // 16K x 8, maps onto one block RAM pair
  logic [`MSU_DATA_W-1:0] mem [0:`MSU_BUF_DEPTH-1];

  //////////////////////////////////////////////////////////////////////
  // Program port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port, one clock of latency
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

  // Once the pointer has left reset it must stay fully defined
  a_rd_addr_known : assert property (
    @(posedge clkin)
    !$isunknown($past(rd_addr)) |-> !$isunknown(rd_addr)
  );

endmodule

`default_nettype wire

// File: msu/msu_bus_sync.sv
`timescale 1ns/1ps
`include "msu_defines.svh"
`default_nettype none

module msu_bus_sync (
  input  logic                   clkin,
  input  logic                   reset,
  input  logic                   enable,
  input  logic [`MSU_REG_AW-1:0] reg_addr,
  input  logic                   reg_oe,
  input  logic                   reg_we,
  input  logic                   status_reset_we,
  input  logic                   msu_address_ext_write,
  msu_bus_if.sync                bus
);

  // Four low samples then one high, oldest sample on the left
  localparam logic [4:0] EDGE_RISE = 5'b00001;
  localparam logic [4:0] EDGE_FALL = 5'b11110;

  logic [3:0][`MSU_REG_AW-1:0] addr_sr;
  logic [4:0]                  enable_sr;
  logic [5:0]                  oe_sr;
  logic [5:0]                  we_sr;
  logic [2:0]                  ext_wr_sr;
  logic [1:0]                  status_sr;

  //////////////////////////////////////////////////////////////////////
  // Input samplers
  //////////////////////////////////////////////////////////////////////

  // Strobe samplers start high so an idle-high line gives no edge
  always_ff @(posedge clkin) begin
    if (reset) begin
      addr_sr   <= '0;
      enable_sr <= '1;
      oe_sr     <= '1;
      we_sr     <= '1;
      ext_wr_sr <= '1;
      status_sr <= '1;
    end else begin
      addr_sr   <= {addr_sr[2:0], reg_addr};
      enable_sr <= {enable_sr[3:0], enable};
      oe_sr     <= {oe_sr[4:0], reg_oe};
      we_sr     <= {we_sr[4:0], reg_we};
      ext_wr_sr <= {ext_wr_sr[1:0], msu_address_ext_write};
      status_sr <= {status_sr[0], status_reset_we};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Edge detection
  //////////////////////////////////////////////////////////////////////

  // Read mux lags write decode by two clocks
  assign bus.rd_addr = msu_regs_pkg::msu_rd_reg_e'(addr_sr[3]);
  assign bus.wr_addr = msu_regs_pkg::msu_wr_reg_e'(addr_sr[1]);

  // Rising edges use the older enable sample, the falling edge a recent one
  assign bus.oe_rise = enable_sr[4] && (oe_sr[5:1] == EDGE_RISE);
  assign bus.oe_fall = enable_sr[1] && (oe_sr[5:1] == EDGE_FALL);
  assign bus.we_rise = enable_sr[4] && (we_sr[5:1] == EDGE_RISE);

  // MCU side lines are not qualified by enable
  assign bus.ptr_load      = (ext_wr_sr[2:1] == 2'b01);
  assign bus.status_update = (status_sr == 2'b01);

  // A write edge never lands on either edge of a read cycle
  a_rd_wr_edges_exclusive : assert property (
    @(posedge clkin) disable iff (reset)
    !(bus.we_rise && (bus.oe_rise || bus.oe_fall))
  );

endmodule

`default_nettype wire

// File: msu/msu_regs.sv
`timescale 1ns/1ps
`include "msu_defines.svh"
`default_nettype none

module msu_regs (
  input  logic                          clkin,
  input  logic                          reset,
  msu_bus_if.regs                       bus,
  input  logic [`MSU_DATA_W-1:0]        reg_data_in,
  input  logic [`MSU_BUF_AW-1:0]        pgm_address,
  input  logic [`MSU_DATA_W-1:0]        pgm_data,
  input  logic                          pgm_we,
  input  logic [`MSU_BUF_AW-1:0]        msu_address_ext,
  input  msu_mcu_pkg::msu_status_bits_t status_set_bits,
  input  msu_mcu_pkg::msu_status_bits_t status_reset_bits,
  output logic [`MSU_DATA_W-1:0]        reg_data_out,
  output msu_mcu_pkg::msu_status_out_t  status_out,
  output logic [`MSU_DATA_W-1:0]        volume_out,
  output logic                          volume_latch_out,
  output logic [`MSU_SEEK_W-1:0]        addr_out,
  output logic [`MSU_TRACK_W-1:0]       track_out
);

  logic [`MSU_BUF_AW-1:0] ptr;
  logic [`MSU_DATA_W-1:0] buf_data;

  logic       audio_start;
  logic       audio_busy;
  logic       data_start;
  logic       data_busy;
  logic       ctrl_start;
  logic [1:0] audio_ctrl;
  logic [1:0] audio_status;

  // Program port is active low
  msu_databuf u_databuf (
    .clkin   (clkin),
    .wr_addr (pgm_address),
    .wr_data (pgm_data),
    .wr_en   (~pgm_we),
    .rd_addr (ptr),
    .rd_data (buf_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Console writes and MCU status updates
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset) begin
      addr_out         <= '0;
      track_out        <= '0;
      volume_out       <= '0;
      volume_latch_out <= 1'b0;
      audio_start      <= 1'b0;
      audio_busy       <= 1'b1;
      data_start       <= 1'b0;
      data_busy        <= 1'b1;
      ctrl_start       <= 1'b0;
      audio_ctrl       <= '0;
      audio_status     <= '0;
    end else begin
      volume_latch_out <= 1'b0;
      if (bus.we_rise) begin
        case (bus.wr_addr)
          msu_regs_pkg::WR_ADDR0:    addr_out[7:0]   <= reg_data_in;
          msu_regs_pkg::WR_ADDR1:    addr_out[15:8]  <= reg_data_in;
          msu_regs_pkg::WR_ADDR2:    addr_out[23:16] <= reg_data_in;
          msu_regs_pkg::WR_ADDR3: begin
            // Top byte completes the seek
            addr_out[31:24] <= reg_data_in;
            data_start      <= 1'b1;
            data_busy       <= 1'b1;
          end
          msu_regs_pkg::WR_TRACK_LO: track_out[7:0]  <= reg_data_in;
          msu_regs_pkg::WR_TRACK_HI: begin
            track_out[15:8] <= reg_data_in;
            audio_start     <= 1'b1;
            audio_busy      <= 1'b1;
          end
          msu_regs_pkg::WR_VOLUME: begin
            volume_out       <= reg_data_in;
            volume_latch_out <= 1'b1;
          end
          msu_regs_pkg::WR_CONTROL: begin
            // Ignored while a track is still being prepared
            if (!audio_busy) begin
              audio_ctrl <= reg_data_in[1:0];
              ctrl_start <= 1'b1;
            end
          end
        endcase
      end else if (bus.status_update) begin
        // Set first, then reset, bit by bit
        audio_busy   <= (audio_busy | status_set_bits.audio_busy)
                        & ~status_reset_bits.audio_busy;
        data_busy    <= (data_busy | status_set_bits.data_busy)
                        & ~status_reset_bits.data_busy;
        audio_status <= (audio_status | status_set_bits.audio_status)
                        & ~status_reset_bits.audio_status;
        ctrl_start   <= (ctrl_start | status_set_bits.ctrl_start)
                        & ~status_reset_bits.ctrl_start;
        if (status_reset_bits.audio_busy) audio_start <= 1'b0;
        if (status_reset_bits.data_busy) data_start <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data port pointer and read mux
  //////////////////////////////////////////////////////////////////////

  // MCU load wins over a console read in the same clock
  always_ff @(posedge clkin) begin
    if (reset) begin
      ptr <= '0;
    end else if (bus.ptr_load) begin
      ptr <= msu_address_ext;
    end else if (bus.oe_rise && bus.rd_addr == msu_regs_pkg::RD_DATA) begin
      ptr <= ptr + 1'b1;
    end
  end

  always_ff @(posedge clkin) begin
    case (bus.rd_addr)
      msu_regs_pkg::RD_STATUS: begin
        reg_data_out <= {data_busy, audio_busy, audio_status,
                         msu_regs_pkg::MSU_STATUS_REV};
      end
      msu_regs_pkg::RD_DATA: reg_data_out <= buf_data;
      msu_regs_pkg::RD_ID0:  reg_data_out <= msu_regs_pkg::MSU_ID[0];
      msu_regs_pkg::RD_ID1:  reg_data_out <= msu_regs_pkg::MSU_ID[1];
      msu_regs_pkg::RD_ID2:  reg_data_out <= msu_regs_pkg::MSU_ID[2];
      msu_regs_pkg::RD_ID3:  reg_data_out <= msu_regs_pkg::MSU_ID[3];
      msu_regs_pkg::RD_ID4:  reg_data_out <= msu_regs_pkg::MSU_ID[4];
      msu_regs_pkg::RD_ID5:  reg_data_out <= msu_regs_pkg::MSU_ID[5];
    endcase
  end

  always_comb begin
    status_out.ptr_msb      = ptr[`MSU_BUF_AW-1];
    status_out.audio_start  = audio_start;
    status_out.data_start   = data_start;
    status_out.volume_latch = volume_latch_out;
    status_out.audio_ctrl   = audio_ctrl;
    status_out.ctrl_start   = ctrl_start;
  end

  // Latch is a single clock even if a status update follows the write
  a_volume_latch_pulse : assert property (
    @(posedge clkin) disable iff (reset)
    volume_latch_out |=> !volume_latch_out
  );

  // Console control writes cannot start playback over a busy track
  a_ctrl_start_gated : assert property (
    @(posedge clkin) disable iff (reset)
    ($rose(ctrl_start) && !$past(bus.status_update)) |-> !$past(audio_busy)
  );

endmodule

`default_nettype wire

// File: design/msu_top.sv
`timescale 1ns/1ps
`include "msu_defines.svh"
`default_nettype none

module msu_top (
  input  logic                   clkin,
  input  logic                   reset,
  input  logic                   enable,
  input  logic [`MSU_BUF_AW-1:0] pgm_address,
  input  logic [`MSU_DATA_W-1:0] pgm_data,
  input  logic                   pgm_we,
  input  logic [`MSU_REG_AW-1:0] reg_addr,
  input  logic [`MSU_DATA_W-1:0] reg_data_in,
  input  logic                   reg_oe,
  input  logic                   reg_we,
  input  logic [$bits(msu_mcu_pkg::msu_status_bits_t)-1:0] status_reset_bits,
  input  logic [$bits(msu_mcu_pkg::msu_status_bits_t)-1:0] status_set_bits,
  input  logic                   status_reset_we,
  input  logic [`MSU_BUF_AW-1:0] msu_address_ext,
  input  logic                   msu_address_ext_write,
  output logic [`MSU_DATA_W-1:0] reg_data_out,
  output logic [$bits(msu_mcu_pkg::msu_status_out_t)-1:0]  status_out,
  output logic [`MSU_DATA_W-1:0] volume_out,
  output logic                   volume_latch_out,
  output logic [`MSU_SEEK_W-1:0] addr_out,
  output logic [`MSU_TRACK_W-1:0] track_out
);

  msu_mcu_pkg::msu_status_out_t status_s;

  msu_bus_if u_bus ();

  //////////////////////////////////////////////////////////////////////
  // Bus sampling
  //////////////////////////////////////////////////////////////////////

  msu_bus_sync u_bus_sync (
    .clkin                 (clkin),
    .reset                 (reset),
    .enable                (enable),
    .reg_addr              (reg_addr),
    .reg_oe                (reg_oe),
    .reg_we                (reg_we),
    .status_reset_we       (status_reset_we),
    .msu_address_ext_write (msu_address_ext_write),
    .bus                   (u_bus)
  );

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  msu_regs u_regs (
    .clkin             (clkin),
    .reset             (reset),
    .bus               (u_bus),
    .reg_data_in       (reg_data_in),
    .pgm_address       (pgm_address),
    .pgm_data          (pgm_data),
    .pgm_we            (pgm_we),
    .msu_address_ext   (msu_address_ext),
    .status_set_bits   (msu_mcu_pkg::msu_status_bits_t'(status_set_bits)),
    .status_reset_bits (msu_mcu_pkg::msu_status_bits_t'(status_reset_bits)),
    .reg_data_out      (reg_data_out),
    .status_out        (status_s),
    .volume_out        (volume_out),
    .volume_latch_out  (volume_latch_out),
    .addr_out          (addr_out),
    .track_out         (track_out)
  );

  // Flatten the status flags for the MCU pins
  assign status_out = $bits(status_out)'(status_s);

endmodule

`default_nettype wire

// File: dv/msu_tb.sv
`timescale 1ns/1ps
`include "msu_defines.svh"
`default_nettype none

module msu_tb;

  // Clocks each bus level is held before the next change or check
  localparam int HOLD = 8;
  // About 75 transactions of under 20 clocks each, well inside this
  localparam int MAX_CYCLES = 20000;

  logic                    clkin;
  logic                    reset;
  logic                    enable;
  logic [`MSU_BUF_AW-1:0]  pgm_address;
  logic [`MSU_DATA_W-1:0]  pgm_data;
  logic                    pgm_we;
  logic [`MSU_REG_AW-1:0]  reg_addr;
  logic [`MSU_DATA_W-1:0]  reg_data_in;
  logic                    reg_oe;
  logic                    reg_we;
  logic [5:0]              status_reset_bits;
  logic [5:0]              status_set_bits;
  logic                    status_reset_we;
  logic [`MSU_BUF_AW-1:0]  msu_address_ext;
  logic                    msu_address_ext_write;
  logic [`MSU_DATA_W-1:0]  reg_data_out;
  logic [6:0]              status_out;
  logic [`MSU_DATA_W-1:0]  volume_out;
  logic                    volume_latch_out;
  logic [`MSU_SEEK_W-1:0]  addr_out;
  logic [`MSU_TRACK_W-1:0] track_out;

  // Scoreboard model
  logic [7:0]             mem_model [0:`MSU_BUF_DEPTH-1];
  logic [31:0]            m_addr;
  logic [15:0]            m_track;
  logic [7:0]             m_volume;
  logic [`MSU_BUF_AW-1:0] m_ptr;
  logic                   m_audio_busy;
  logic                   m_data_busy;
  logic                   m_audio_start;
  logic                   m_data_start;
  logic                   m_ctrl_start;
  logic [1:0]             m_audio_ctrl;
  logic [1:0]             m_audio_status;
  int                     m_latch_count;
  int                     latch_count;
  int                     status_latch_count;
  int                     cycle_count = 0;
  integer                 seed = 32'h7dbc;

  msu_top u_msu_top (.*);

  always #50 clkin = ~clkin;

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and comparison
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected) else begin
      stop_on_error($sformatf("mismatch at %0d ns: %s expected %0h, actual %0h",
                              $time, name, expected, actual));
    end
  endtask

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  // Register 0: data_busy, audio_busy, audio_status, then revision 0001
  function automatic logic [7:0] status_byte();
    return {m_data_busy, m_audio_busy, m_audio_status, 4'b0001};
  endfunction

  // Latch bit is expected low once the bus has settled
  function automatic logic [6:0] status_flags();
    return {m_ptr[`MSU_BUF_AW-1], m_audio_start, m_data_start, 1'b0,
            m_audio_ctrl, m_ctrl_start};
  endfunction

  task automatic compare_outputs();
    @(negedge clkin);
    expect_equal("addr_out", m_addr, addr_out);
    expect_equal("track_out", 32'(m_track), 32'(track_out));
    expect_equal("volume_out", 32'(m_volume), 32'(volume_out));
    expect_equal("status_out", 32'(status_flags()), 32'(status_out));
    expect_equal("volume_latch_out pulses", m_latch_count, latch_count);
    expect_equal("status_out[3] pulses", m_latch_count, status_latch_count);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and MCU stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clkin);
  endtask

  task automatic bus_write(input msu_regs_pkg::msu_wr_reg_e addr, input logic [7:0] data);
    @(posedge clkin);
    reg_addr    <= addr;
    reg_data_in <= data;
    reg_we      <= 1'b0;
    wait_cycles(HOLD);
    reg_we <= 1'b1;
    wait_cycles(HOLD);
    if (enable) begin
      case (addr)
        msu_regs_pkg::WR_ADDR0:    m_addr[7:0]   = data;
        msu_regs_pkg::WR_ADDR1:    m_addr[15:8]  = data;
        msu_regs_pkg::WR_ADDR2:    m_addr[23:16] = data;
        msu_regs_pkg::WR_ADDR3: begin
          m_addr[31:24] = data;
          m_data_start  = 1'b1;
          m_data_busy   = 1'b1;
        end
        msu_regs_pkg::WR_TRACK_LO: m_track[7:0]  = data;
        msu_regs_pkg::WR_TRACK_HI: begin
          m_track[15:8] = data;
          m_audio_start = 1'b1;
          m_audio_busy  = 1'b1;
        end
        msu_regs_pkg::WR_VOLUME: begin
          m_volume      = data;
          m_latch_count = m_latch_count + 1;
        end
        msu_regs_pkg::WR_CONTROL: begin
          if (!m_audio_busy) begin
            m_audio_ctrl = data[1:0];
            m_ctrl_start = 1'b1;
          end
        end
      endcase
    end
    compare_outputs();
  endtask

  // Data is taken while the strobe is low, the pointer moves on release
  task automatic bus_read(input msu_regs_pkg::msu_rd_reg_e addr, output logic [7:0] data);
    @(posedge clkin);
    reg_addr <= addr;
    reg_oe   <= 1'b0;
    wait_cycles(HOLD);
    @(negedge clkin);
    data = reg_data_out;
    @(posedge clkin);
    reg_oe <= 1'b1;
    wait_cycles(HOLD);
    if (enable && addr == msu_regs_pkg::RD_DATA) begin
      m_ptr = m_ptr + 1'b1;
    end
    compare_outputs();
  endtask

  task automatic read_and_check(input msu_regs_pkg::msu_rd_reg_e addr,
                                input logic [7:0] expected, input string name);
    logic [7:0] value;
    bus_read(addr, value);
    expect_equal(name, 32'(expected), 32'(value));
  endtask

  // Program port is active low
  task automatic pgm_write(input logic [`MSU_BUF_AW-1:0] addr, input logic [7:0] data);
    @(posedge clkin);
    pgm_address <= addr;
    pgm_data    <= data;
    pgm_we      <= 1'b0;
    @(posedge clkin);
    pgm_we <= 1'b1;
    mem_model[addr] = data;
  endtask

  task automatic ptr_load(input logic [`MSU_BUF_AW-1:0] addr);
    @(posedge clkin);
    msu_address_ext <= addr;
    @(posedge clkin);
    msu_address_ext_write <= 1'b1;
    wait_cycles(HOLD);
    msu_address_ext_write <= 1'b0;
    wait_cycles(HOLD);
    m_ptr = addr;
    compare_outputs();
  endtask

  // Bits: audio_busy 5, data_busy 4, volume 3, audio_status 2:1, ctrl_start 0
  task automatic status_strobe(input logic [5:0] set_bits, input logic [5:0] rst_bits);
    @(posedge clkin);
    status_set_bits   <= set_bits;
    status_reset_bits <= rst_bits;
    @(posedge clkin);
    status_reset_we <= 1'b1;
    wait_cycles(HOLD);
    status_reset_we <= 1'b0;
    wait_cycles(HOLD);
    m_audio_busy   = (m_audio_busy | set_bits[5]) & ~rst_bits[5];
    m_data_busy    = (m_data_busy | set_bits[4]) & ~rst_bits[4];
    m_audio_status = (m_audio_status | set_bits[2:1]) & ~rst_bits[2:1];
    m_ctrl_start   = (m_ctrl_start | set_bits[0]) & ~rst_bits[0];
    if (rst_bits[5]) m_audio_start = 1'b0;
    if (rst_bits[4]) m_data_start = 1'b0;
    compare_outputs();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequences
  //////////////////////////////////////////////////////////////////////

  task automatic id_and_reset_values();
    msu_regs_pkg::msu_rd_reg_e addr;
    read_and_check(msu_regs_pkg::RD_STATUS, status_byte(), "status register");
    for (int i = 0; i < 6; i++) begin
      addr = msu_regs_pkg::msu_rd_reg_e'(3'(i + 2));
      read_and_check(addr, msu_regs_pkg::MSU_ID[i], $sformatf("id register %0d", i + 2));
    end
  endtask

  task automatic seek_track_volume();
    // Drop both busy flags first so the writes visibly raise them
    status_strobe(6'b000000, 6'b110000);
    bus_write(msu_regs_pkg::WR_ADDR0, rand_byte());
    bus_write(msu_regs_pkg::WR_ADDR1, rand_byte());
    bus_write(msu_regs_pkg::WR_ADDR2, rand_byte());
    bus_write(msu_regs_pkg::WR_ADDR3, rand_byte());
    bus_write(msu_regs_pkg::WR_TRACK_LO, rand_byte());
    bus_write(msu_regs_pkg::WR_TRACK_HI, rand_byte());
    bus_write(msu_regs_pkg::WR_VOLUME, rand_byte());
    read_and_check(msu_regs_pkg::RD_STATUS, status_byte(), "status register");
  endtask

  task automatic data_port_reads();
    logic [`MSU_BUF_AW-1:0] base;
    // Second run crosses into the upper half of the buffer
    for (int run = 0; run < 2; run++) begin
      base = (run == 0) ? 14'h0010 : 14'h1ffc;
      for (int i = 0; i < 8; i++) begin
        pgm_write(base + 14'(i), rand_byte());
      end
      ptr_load(base);
      for (int i = 0; i < 8; i++) begin
        read_and_check(msu_regs_pkg::RD_DATA, mem_model[m_ptr], "reg_data_out");
      end
    end
  endtask

  task automatic status_word_updates();
    status_strobe(6'b000111, 6'b000000);
    read_and_check(msu_regs_pkg::RD_STATUS, status_byte(), "status register");
    // Same bit set and reset, reset wins and the start flags drop
    status_strobe(6'b110000, 6'b110010);
    read_and_check(msu_regs_pkg::RD_STATUS, status_byte(), "status register");
    status_strobe(6'b010000, 6'b000001);
    read_and_check(msu_regs_pkg::RD_STATUS, status_byte(), "status register");
  endtask

  task automatic control_gating();
    status_strobe(6'b100000, 6'b000000);
    bus_write(msu_regs_pkg::WR_CONTROL, 8'h03);
    status_strobe(6'b000000, 6'b100000);
    bus_write(msu_regs_pkg::WR_CONTROL, 8'h02);
    read_and_check(msu_regs_pkg::RD_STATUS, status_byte(), "status register");
  endtask

  task automatic enable_gating();
    logic [7:0] first;
    logic [7:0] second;
    ptr_load(14'h1ffc);
    @(posedge clkin);
    enable <= 1'b0;
    wait_cycles(HOLD);
    // Inverted data so that any accepted write would show
    bus_write(msu_regs_pkg::WR_ADDR0, ~m_addr[7:0]);
    bus_write(msu_regs_pkg::WR_TRACK_HI, ~m_track[15:8]);
    bus_write(msu_regs_pkg::WR_VOLUME, ~m_volume);
    bus_read(msu_regs_pkg::RD_DATA, first);
    bus_read(msu_regs_pkg::RD_DATA, second);
    expect_equal("reg_data_out", 32'(mem_model[m_ptr]), 32'(first));
    expect_equal("reg_data_out", 32'(mem_model[m_ptr]), 32'(second));
    @(posedge clkin);
    enable <= 1'b1;
    wait_cycles(HOLD);
    read_and_check(msu_regs_pkg::RD_DATA, mem_model[m_ptr], "reg_data_out");
    read_and_check(msu_regs_pkg::RD_DATA, mem_model[m_ptr], "reg_data_out");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitors and run control
  //////////////////////////////////////////////////////////////////////

  // Latch pulses seen on the dedicated pin and in the status flags
  always @(posedge clkin) begin
    if (reset) begin
      latch_count        <= 0;
      status_latch_count <= 0;
    end else begin
      if (volume_latch_out) latch_count <= latch_count + 1;
      if (status_out[3]) status_latch_count <= status_latch_count + 1;
    end
  end

  always @(posedge clkin) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      stop_on_error("timeout: the tests did not finish within the cycle limit");
    end
  end

  a_latch_one_cycle : assert property (
    @(posedge clkin) disable iff (reset)
    volume_latch_out |=> !volume_latch_out
  ) else stop_on_error("volume_latch_out stayed high for more than one cycle");

  initial begin
    clkin                 = 1'b0;
    reset                 = 1'b1;
    enable                = 1'b1;
    pgm_address           = '0;
    pgm_data              = '0;
    pgm_we                = 1'b1;
    reg_addr              = '0;
    reg_data_in           = '0;
    reg_oe                = 1'b1;
    reg_we                = 1'b1;
    status_reset_bits     = '0;
    status_set_bits       = '0;
    status_reset_we       = 1'b0;
    msu_address_ext       = '0;
    msu_address_ext_write = 1'b0;
    m_addr         = '0;
    m_track        = '0;
    m_volume       = '0;
    m_ptr          = '0;
    m_audio_busy   = 1'b1;
    m_data_busy    = 1'b1;
    m_audio_start  = 1'b0;
    m_data_start   = 1'b0;
    m_ctrl_start   = 1'b0;
    m_audio_ctrl   = '0;
    m_audio_status = '0;
    m_latch_count  = 0;
    wait_cycles(10);
    reset <= 1'b0;
    wait_cycles(HOLD);
    compare_outputs();
    id_and_reset_values();
    seek_track_volume();
    data_port_reads();
    status_word_updates();
    control_gating();
    enable_gating();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/msu_regs_pkg.sv
common/msu_mcu_pkg.sv
common/msu_bus_if.sv
msu/msu_databuf.sv
msu/msu_bus_sync.sv
msu/msu_regs.sv
design/msu_top.sv
dv/msu_tb.sv

// File: Makefile
# Verilator build and run of the MSU register block testbench

BUILD = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal -f verilog.f --top-module msu_tb \
		-Mdir $(BUILD) -o msu_sim
	@out="$$(./$(BUILD)/msu_sim 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD)
